// File: verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH
`default_nettype none

// Instruction memory words, indexed by the low PC bits
`define CPU_IMEM_DEPTH 64

// Data memory words, indexed by the low ALU result bits
`define CPU_DMEM_DEPTH 64

// Architectural registers, r0 hardwired to zero
`define CPU_NUM_REGS 8

`default_nettype wire
`endif

// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Instruction word layout
    //   [15:12] opcode
    //   [11:9]  rs
    //   [8:6]   rt
    //   [5:3]   rd (R-type)
    //   [5:0]   immediate or absolute target
    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_addr_t;
    typedef logic [3:0]  opcode_t;
    typedef logic [5:0]  imm_t;

    // R-type, rd <= rs op rt
    localparam opcode_t OP_ADD  = 4'd0;
    localparam opcode_t OP_SUB  = 4'd1;
    localparam opcode_t OP_AND  = 4'd2;
    localparam opcode_t OP_OR   = 4'd3;
    localparam opcode_t OP_SLT  = 4'd4;

    // I-type, rt is the destination or the store source
    localparam opcode_t OP_ADDI = 4'd5;
    localparam opcode_t OP_LW   = 4'd6;
    localparam opcode_t OP_SW   = 4'd7;

    // Control transfer with absolute targets
    localparam opcode_t OP_BEQ  = 4'd8;
    localparam opcode_t OP_BNE  = 4'd9;
    localparam opcode_t OP_JMP  = 4'd10;

    // Opcodes 11 to 15 do nothing, 15 doubles as the pipeline bubble
    localparam word_t INSTR_NOP = 16'hf000;

endpackage

`default_nettype wire

// File: verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // ALU function chosen in decode
    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    // Data memory access
    typedef logic [1:0] mem_op_t;
    localparam mem_op_t MEM_NONE  = 2'd0;
    localparam mem_op_t MEM_READ  = 2'd1;
    localparam mem_op_t MEM_WRITE = 2'd2;

    // Operand source in execute
    typedef logic [1:0] fwd_sel_t;
    localparam fwd_sel_t FWD_REG = 2'd0;
    localparam fwd_sel_t FWD_WB  = 2'd1;
    localparam fwd_sel_t FWD_MEM = 2'd2;

endpackage

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"
`default_nettype none

module fetch_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  logic            load_req,
    input  isa_pkg::word_t  load_addr,
    input  isa_pkg::word_t  load_data,
    output logic            load_ack,
    input  logic            stall,
    input  logic            jump,
    input  isa_pkg::imm_t   jump_target,
    input  logic            flush,
    input  isa_pkg::imm_t   branch_target,
    output isa_pkg::word_t  if_instr,
    output isa_pkg::word_t  if_pc
);
    import isa_pkg::*;

    localparam int IMEM_AW = $clog2(`CPU_IMEM_DEPTH);

    typedef enum logic {LOAD_IDLE, LOAD_ACK} load_state_t;

    load_state_t load_state;
    logic        load_write;
    word_t       pc;
    word_t       imem [`CPU_IMEM_DEPTH];

    ////////////////////////////////////////////////////////////
    // Four-phase req/ack program load port

    assign load_write = (load_state == LOAD_IDLE) && load_req && !run;
    assign load_ack   = (load_state == LOAD_ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            load_state <= LOAD_IDLE;
        end else if (load_write) begin
            load_state <= LOAD_ACK;
        end else if (!load_req || run) begin
            load_state <= LOAD_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (load_write) begin
            imem[load_addr[IMEM_AW-1:0]] <= load_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // PC and IF/ID latch

    // Redirect priority is flush, then jump, then stall
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            pc       <= '0;
            if_instr <= INSTR_NOP;
            if_pc    <= '0;
        end else if (flush) begin
            pc       <= word_t'(branch_target);
            if_instr <= INSTR_NOP;
        end else if (jump) begin
            pc       <= word_t'(jump_target);
            if_instr <= INSTR_NOP;
        end else if (!stall) begin
            pc       <= pc + 16'd1;
            if_instr <= imem[pc[IMEM_AW-1:0]];
            if_pc    <= pc;
        end
    end

    // Ack is only ever seen while the core is halted
    assert property (@(posedge clk) disable iff (rst) load_ack |-> !run);

endmodule

`default_nettype wire

// File: verilog/decode_unit.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"
`default_nettype none

module decode_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  isa_pkg::word_t      if_instr,
    input  isa_pkg::word_t      if_pc,
    input  logic                wb_valid,
    input  isa_pkg::reg_addr_t  wb_reg,
    input  isa_pkg::word_t      wb_data,
    output logic                stall,
    output logic                jump,
    output isa_pkg::imm_t       jump_target,
    output isa_pkg::reg_addr_t  id_rs,
    output isa_pkg::reg_addr_t  id_rt,
    output isa_pkg::reg_addr_t  id_dst,
    output isa_pkg::word_t      id_rs_data,
    output isa_pkg::word_t      id_rt_data,
    output isa_pkg::word_t      id_imm,
    output pipe_pkg::alu_op_t   id_alu_op,
    output logic                id_alu_src,
    output logic                id_reg_write,
    output logic                id_branch_eq,
    output logic                id_branch_ne,
    output pipe_pkg::mem_op_t   id_mem_op,
    output isa_pkg::imm_t       id_target
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_t   op;
    reg_addr_t rs, rt, rd, dst;
    imm_t      imm;
    logic      r_type, alu_src, reg_write;
    alu_op_t   alu_op;
    mem_op_t   mem_op;
    word_t     rs_data, rt_data;
    word_t     regs [`CPU_NUM_REGS];

    ////////////////////////////////////////////////////////////
    // Field split and control decode

    assign op  = if_instr[15:12];
    assign rs  = if_instr[11:9];
    assign rt  = if_instr[8:6];
    assign rd  = if_instr[5:3];
    assign imm = if_instr[5:0];

    assign r_type    = (op <= OP_SLT);
    assign alu_src   = (op == OP_ADDI) || (op == OP_LW) || (op == OP_SW);
    assign reg_write = r_type || (op == OP_ADDI) || (op == OP_LW);
    assign dst       = r_type ? rd : rt;
    assign mem_op    = (op == OP_LW) ? MEM_READ : (op == OP_SW) ? MEM_WRITE : MEM_NONE;

    // Immediate forms and branches all fall back to add
    always_comb begin
        case (op)
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_SLT:  alu_op = ALU_SLT;
            default: alu_op = ALU_ADD;
        endcase
    end

    assign jump        = (op == OP_JMP);
    assign jump_target = imm;

    // Load in ID/EX feeding this instruction, wait one cycle
    assign stall = (id_mem_op == MEM_READ) && id_reg_write &&
                   (id_dst == rs || id_dst == rt) && !jump;

    ////////////////////////////////////////////////////////////
    // Register file, write-through to the same-cycle read

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_reg] <= wb_data;
        end
    end

    assign rs_data = (wb_valid && wb_reg == rs) ? wb_data : regs[rs];
    assign rt_data = (wb_valid && wb_reg == rt) ? wb_data : regs[rt];

    ////////////////////////////////////////////////////////////
    // ID/EX latch

    always_ff @(posedge clk) begin
        if (rst || flush || stall) begin
            id_reg_write <= 1'b0;
            id_mem_op    <= MEM_NONE;
            id_branch_eq <= 1'b0;
            id_branch_ne <= 1'b0;
        end else begin
            // r0 destination turns into a no-write here
            id_reg_write <= reg_write && (dst != '0);
            id_mem_op    <= mem_op;
            id_branch_eq <= (op == OP_BEQ);
            id_branch_ne <= (op == OP_BNE);
        end
    end

    always_ff @(posedge clk) begin
        id_rs      <= rs;
        id_rt      <= rt;
        id_dst     <= dst;
        id_rs_data <= rs_data;
        id_rt_data <= rt_data;
        id_imm     <= word_t'(imm);
        id_alu_op  <= alu_op;
        id_alu_src <= alu_src;
        id_target  <= imm;
    end

    // Nothing retiring from memory_unit ever lands in r0
    assert property (@(posedge clk) disable iff (rst) wb_valid |-> wb_reg != '0);

    // Fetch keeps the stalled instruction in IF/ID unless it was halted
    assert property (@(posedge clk) disable iff (rst)
        stall && !flush |=> $stable(if_pc) || if_instr == INSTR_NOP);

endmodule

`default_nettype wire

// File: verilog/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  isa_pkg::reg_addr_t  id_rs,
    input  isa_pkg::reg_addr_t  id_rt,
    input  isa_pkg::reg_addr_t  id_dst,
    input  isa_pkg::word_t      id_rs_data,
    input  isa_pkg::word_t      id_rt_data,
    input  isa_pkg::word_t      id_imm,
    input  pipe_pkg::alu_op_t   id_alu_op,
    input  logic                id_alu_src,
    input  logic                id_reg_write,
    input  logic                id_branch_eq,
    input  logic                id_branch_ne,
    input  pipe_pkg::mem_op_t   id_mem_op,
    input  isa_pkg::imm_t       id_target,
    input  logic                wb_valid,
    input  isa_pkg::reg_addr_t  wb_reg,
    input  isa_pkg::word_t      wb_data,
    output isa_pkg::word_t      ex_alu_result,
    output isa_pkg::word_t      ex_store_data,
    output isa_pkg::reg_addr_t  ex_dst,
    output logic                ex_reg_write,
    output pipe_pkg::mem_op_t   ex_mem_op,
    output logic                ex_branch_eq,
    output logic                ex_branch_ne,
    output logic                ex_equal,
    output isa_pkg::imm_t       ex_target
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fwd_sel_t fwd_a, fwd_b;
    word_t    opnd_a, opnd_b, alu_b, alu_y;
    logic     id_active;

    // EX/MEM is the newer producer, so it is checked first
    function automatic fwd_sel_t pick_source(reg_addr_t src);
        if (src != '0 && ex_reg_write && ex_mem_op != MEM_READ && ex_dst == src) begin
            return FWD_MEM;
        end
        if (src != '0 && wb_valid && wb_reg == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    function automatic word_t forward(fwd_sel_t sel, word_t reg_val);
        case (sel)
            FWD_MEM: return ex_alu_result;
            FWD_WB:  return wb_data;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        fwd_a  = pick_source(id_rs);
        fwd_b  = pick_source(id_rt);
        opnd_a = forward(fwd_a, id_rs_data);
        opnd_b = forward(fwd_b, id_rt_data);
        alu_b  = id_alu_src ? id_imm : opnd_b;
    end

    ////////////////////////////////////////////////////////////
    // ALU, slt is unsigned

    always_comb begin
        case (id_alu_op)
            ALU_SUB: alu_y = opnd_a - alu_b;
            ALU_AND: alu_y = opnd_a & alu_b;
            ALU_OR:  alu_y = opnd_a | alu_b;
            ALU_SLT: alu_y = word_t'(opnd_a < alu_b);
            default: alu_y = opnd_a + alu_b;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // EX/MEM latch

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ex_reg_write <= 1'b0;
            ex_mem_op    <= MEM_NONE;
            ex_branch_eq <= 1'b0;
            ex_branch_ne <= 1'b0;
        end else begin
            ex_reg_write <= id_reg_write;
            ex_mem_op    <= id_mem_op;
            ex_branch_eq <= id_branch_eq;
            ex_branch_ne <= id_branch_ne;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_result <= alu_y;
        ex_store_data <= opnd_b;
        ex_dst        <= id_dst;
        ex_equal      <= (opnd_a == opnd_b);
        ex_target     <= id_target;
    end

    assign id_active = id_reg_write || id_mem_op != MEM_NONE || id_branch_eq || id_branch_ne;

    // Decode stall keeps a load's consumer one slot behind it
    assert property (@(posedge clk) disable iff (rst)
        ex_mem_op == MEM_READ && ex_reg_write && id_active |->
            id_rs != ex_dst && id_rt != ex_dst);

endmodule

`default_nettype wire

// File: verilog/memory_unit.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"
`default_nettype none

module memory_unit (
    input  logic                clk,
    input  logic                rst,
    input  isa_pkg::word_t      ex_alu_result,
    input  isa_pkg::word_t      ex_store_data,
    input  isa_pkg::reg_addr_t  ex_dst,
    input  logic                ex_reg_write,
    input  pipe_pkg::mem_op_t   ex_mem_op,
    input  logic                ex_branch_eq,
    input  logic                ex_branch_ne,
    input  logic                ex_equal,
    input  isa_pkg::imm_t       ex_target,
    output logic                flush,
    output isa_pkg::imm_t       branch_target,
    output logic                wb_valid,
    output isa_pkg::reg_addr_t  wb_reg,
    output isa_pkg::word_t      wb_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int DMEM_AW = $clog2(`CPU_DMEM_DEPTH);

    logic [DMEM_AW-1:0] addr;
    logic               wb_is_load;
    word_t              wb_alu, wb_load;
    word_t              dmem [`CPU_DMEM_DEPTH];

    assign addr = ex_alu_result[DMEM_AW-1:0];

    always_ff @(posedge clk) begin
        if (ex_mem_op == MEM_WRITE) begin
            dmem[addr] <= ex_store_data;
        end
    end

    // Branch taken, drop the three younger instructions
    assign flush         = (ex_branch_eq && ex_equal) || (ex_branch_ne && !ex_equal);
    assign branch_target = ex_target;

    ////////////////////////////////////////////////////////////
    // MEM/WB latch and writeback select

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid   <= 1'b0;
            wb_is_load <= 1'b0;
        end else begin
            wb_valid   <= ex_reg_write;
            wb_is_load <= (ex_mem_op == MEM_READ);
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= ex_dst;
        wb_alu  <= ex_alu_result;
        wb_load <= dmem[addr];
    end

    assign wb_data = wb_is_load ? wb_load : wb_alu;

endmodule

`default_nettype wire

// File: verilog/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    input  logic                load_req,
    input  isa_pkg::word_t      load_addr,
    input  isa_pkg::word_t      load_data,
    output logic                load_ack,
    output logic                wb_valid,
    output isa_pkg::reg_addr_t  wb_reg,
    output isa_pkg::word_t      wb_data
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // IF/ID and redirects
    word_t     if_instr, if_pc;
    logic      stall, jump, flush;
    imm_t      jump_target, branch_target;

    // ID/EX
    reg_addr_t id_rs, id_rt, id_dst;
    word_t     id_rs_data, id_rt_data, id_imm;
    alu_op_t   id_alu_op;
    mem_op_t   id_mem_op;
    logic      id_alu_src, id_reg_write, id_branch_eq, id_branch_ne;
    imm_t      id_target;

    // EX/MEM
    word_t     ex_alu_result, ex_store_data;
    reg_addr_t ex_dst;
    mem_op_t   ex_mem_op;
    logic      ex_reg_write, ex_branch_eq, ex_branch_ne, ex_equal;
    imm_t      ex_target;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst), .run(run),
        .load_req(load_req), .load_addr(load_addr), .load_data(load_data),
        .load_ack(load_ack),
        .stall(stall), .jump(jump), .jump_target(jump_target),
        .flush(flush), .branch_target(branch_target),
        .if_instr(if_instr), .if_pc(if_pc)
    );

    decode_unit u_decode (
        .clk(clk), .rst(rst), .flush(flush),
        .if_instr(if_instr), .if_pc(if_pc),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
        .stall(stall), .jump(jump), .jump_target(jump_target),
        .id_rs(id_rs), .id_rt(id_rt), .id_dst(id_dst),
        .id_rs_data(id_rs_data), .id_rt_data(id_rt_data), .id_imm(id_imm),
        .id_alu_op(id_alu_op), .id_alu_src(id_alu_src), .id_reg_write(id_reg_write),
        .id_branch_eq(id_branch_eq), .id_branch_ne(id_branch_ne),
        .id_mem_op(id_mem_op), .id_target(id_target)
    );

    execute_unit u_execute (
        .clk(clk), .rst(rst), .flush(flush),
        .id_rs(id_rs), .id_rt(id_rt), .id_dst(id_dst),
        .id_rs_data(id_rs_data), .id_rt_data(id_rt_data), .id_imm(id_imm),
        .id_alu_op(id_alu_op), .id_alu_src(id_alu_src), .id_reg_write(id_reg_write),
        .id_branch_eq(id_branch_eq), .id_branch_ne(id_branch_ne),
        .id_mem_op(id_mem_op), .id_target(id_target),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
        .ex_alu_result(ex_alu_result), .ex_store_data(ex_store_data),
        .ex_dst(ex_dst), .ex_reg_write(ex_reg_write), .ex_mem_op(ex_mem_op),
        .ex_branch_eq(ex_branch_eq), .ex_branch_ne(ex_branch_ne),
        .ex_equal(ex_equal), .ex_target(ex_target)
    );

    memory_unit u_memory (
        .clk(clk), .rst(rst),
        .ex_alu_result(ex_alu_result), .ex_store_data(ex_store_data),
        .ex_dst(ex_dst), .ex_reg_write(ex_reg_write), .ex_mem_op(ex_mem_op),
        .ex_branch_eq(ex_branch_eq), .ex_branch_ne(ex_branch_ne),
        .ex_equal(ex_equal), .ex_target(ex_target),
        .flush(flush), .branch_target(branch_target),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
    );

endmodule

`default_nettype wire

// File: tb/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk
);

    // 8 ns period, first rising edge at 4 ns
    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

endmodule

`default_nettype wire

// File: tb/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"
`default_nettype none

module cpu_tb;
    import isa_pkg::*;

    localparam int LOAD_TIMEOUT  = 20;
    localparam int TRACE_TIMEOUT = 40;
    localparam int DRAIN_CYCLES  = 10;

    logic      clk, rst, run;
    logic      load_req, load_ack;
    word_t     load_addr, load_data;
    logic      wb_valid;
    reg_addr_t wb_reg;
    word_t     wb_data;

    logic [31:0] lfsr;
    word_t       model_regs [`CPU_NUM_REGS];
    word_t       model_mem [`CPU_DMEM_DEPTH];
    reg_addr_t   exp_reg [$];
    word_t       exp_data [$];

    clock_gen u_clock_gen (
        .clk(clk)
    );

    cpu u_cpu (
        .clk(clk), .rst(rst), .run(run),
        .load_req(load_req), .load_addr(load_addr), .load_data(load_data),
        .load_ack(load_ack),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    ////////////////////////////////////////////////////////////
    // Reporting and timing helpers

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic report_timeout(input string msg);
        $display("Timed out waiting for %s at %0t ns", msg, $time);
        $display("Some tests failed");
        $fatal(1, "stopping on timeout");
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        logic fb;
        v = '0;
        repeat (n) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
    endtask

    function automatic word_t enc_r(opcode_t op, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
        return {op, rs, rt, rd, 3'b000};
    endfunction

    // Also used for branches (rs, rt, target) and jmp
    function automatic word_t enc_i(opcode_t op, reg_addr_t rt, reg_addr_t rs, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    ////////////////////////////////////////////////////////////
    // Sequential ISA model

    task automatic model_write(input reg_addr_t r, input word_t v);
        if (r != 3'd0) begin
            model_regs[r] = v;
            exp_reg.push_back(r);
            exp_data.push_back(v);
        end
    endtask

    task automatic model_run(input word_t prog[$]);
        int        pc;
        int        steps;
        word_t     ins;
        opcode_t   op;
        reg_addr_t rs, rt, rd;
        imm_t      imm;
        word_t     a, b, addr;
        for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        exp_reg.delete();
        exp_data.delete();
        pc    = 0;
        steps = 0;
        while (pc < prog.size() && steps < 200) begin
            ins   = prog[pc];
            op    = ins[15:12];
            rs    = ins[11:9];
            rt    = ins[8:6];
            rd    = ins[5:3];
            imm   = ins[5:0];
            a     = model_regs[rs];
            b     = model_regs[rt];
            addr  = a + word_t'(imm);
            pc    = pc + 1;
            steps = steps + 1;
            case (op)
                OP_ADD:  model_write(rd, a + b);
                OP_SUB:  model_write(rd, a - b);
                OP_AND:  model_write(rd, a & b);
                OP_OR:   model_write(rd, a | b);
                OP_SLT:  model_write(rd, word_t'(a < b));
                OP_ADDI: model_write(rt, addr);
                OP_LW:   model_write(rt, model_mem[addr[5:0]]);
                OP_SW:   model_mem[addr[5:0]] = b;
                OP_BEQ:  if (a == b) pc = int'(imm);
                OP_BNE:  if (a != b) pc = int'(imm);
                OP_JMP:  pc = int'(imm);
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Program load and run

    task automatic load_word(input word_t addr, input word_t data);
        int waited;
        assert (load_ack == 1'b0) else report_mismatch("load_ack high before request");
        load_req  = 1'b1;
        load_addr = addr;
        load_data = data;
        waited    = 0;
        tick();
        while (!load_ack) begin
            if (waited == LOAD_TIMEOUT) report_timeout("load_ack to rise");
            tick();
            waited++;
        end
        load_req = 1'b0;
        waited   = 0;
        tick();
        while (load_ack) begin
            if (waited == LOAD_TIMEOUT) report_timeout("load_ack to fall");
            tick();
            waited++;
        end
    endtask

    // Unused words get a no-op that still carries its address
    task automatic load_program(input word_t prog[$]);
        word_t w;
        for (int i = 0; i < `CPU_IMEM_DEPTH; i++) begin
            if (i < prog.size()) begin
                w = prog[i];
            end else begin
                w = 16'hf000 | word_t'(i);
            end
            load_word(word_t'(i), w);
        end
    endtask

    task automatic run_test(input string name, input word_t prog[$]);
        int waited;
        model_run(prog);
        load_program(prog);
        rst = 1'b1;
        tick();
        tick();
        rst = 1'b0;
        run = 1'b1;
        for (int n = 0; n < exp_reg.size(); n++) begin
            waited = 0;
            tick();
            while (!wb_valid) begin
                if (waited == TRACE_TIMEOUT) report_timeout($sformatf("%s trace event", name));
                tick();
                waited++;
            end
            assert (wb_reg == exp_reg[n] && wb_data == exp_data[n])
                else report_mismatch($sformatf("%s event %0d got r%0d=%h, expected r%0d=%h",
                    name, n, wb_reg, wb_data, exp_reg[n], exp_data[n]));
        end
        // Skipped or extra instructions would show up here
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            tick();
            assert (!wb_valid)
                else report_mismatch($sformatf("%s unexpected event r%0d=%h",
                    name, wb_reg, wb_data));
        end
        run = 1'b0;
        tick();
        $display("%s: %0d trace events checked", name, exp_reg.size());
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_load_port();
        word_t prog[$];
        prog.push_back(enc_i(OP_ADDI, 3'd1, 3'd0, 6'd42));
        run_test("load_port", prog);
        // Requests are ignored while running
        run      = 1'b1;
        load_req = 1'b1;
        repeat (4) begin
            tick();
            assert (!load_ack) else report_mismatch("load_ack rose while run was high");
        end
        load_req = 1'b0;
        run      = 1'b0;
        tick();
    endtask

    task automatic test_alu_forwarding();
        word_t prog[$];
        prog.push_back(enc_i(OP_ADDI, 3'd1, 3'd0, 6'd7));
        prog.push_back(enc_i(OP_ADDI, 3'd2, 3'd1, 6'd3));
        prog.push_back(enc_r(OP_ADD, 3'd3, 3'd1, 3'd2));
        prog.push_back(enc_r(OP_SUB, 3'd4, 3'd3, 3'd1));
        prog.push_back(enc_r(OP_SLT, 3'd5, 3'd1, 3'd4));
        prog.push_back(enc_r(OP_SLT, 3'd6, 3'd4, 3'd1));
        prog.push_back(enc_r(OP_ADD, 3'd0, 3'd3, 3'd3));
        prog.push_back(enc_i(OP_ADDI, 3'd0, 3'd1, 6'd5));
        prog.push_back(enc_r(OP_OR, 3'd7, 3'd5, 3'd3));
        prog.push_back(enc_r(OP_AND, 3'd1, 3'd7, 3'd2));
        prog.push_back(enc_r(OP_ADD, 3'd2, 3'd0, 3'd1));
        run_test("alu_forwarding", prog);
    endtask

    task automatic test_memory_and_load_use();
        word_t prog[$];
        prog.push_back(enc_i(OP_ADDI, 3'd1, 3'd0, 6'd20));
        prog.push_back(enc_i(OP_ADDI, 3'd2, 3'd0, 6'd3));
        prog.push_back(enc_i(OP_SW, 3'd1, 3'd2, 6'd4));
        prog.push_back(enc_i(OP_LW, 3'd3, 3'd0, 6'd7));
        prog.push_back(enc_r(OP_ADD, 3'd4, 3'd3, 3'd1));
        prog.push_back(enc_i(OP_LW, 3'd5, 3'd2, 6'd4));
        prog.push_back(enc_i(OP_SW, 3'd5, 3'd0, 6'd10));
        prog.push_back(enc_i(OP_LW, 3'd6, 3'd0, 6'd10));
        prog.push_back(enc_r(OP_ADD, 3'd7, 3'd6, 3'd6));
        run_test("memory_load_use", prog);
    endtask

    task automatic test_control_flow();
        word_t prog[$];
        prog.push_back(enc_i(OP_ADDI, 3'd1, 3'd0, 6'd5));
        prog.push_back(enc_i(OP_ADDI, 3'd2, 3'd0, 6'd5));
        prog.push_back(enc_i(OP_BEQ, 3'd2, 3'd1, 6'd5));
        prog.push_back(enc_i(OP_ADDI, 3'd3, 3'd0, 6'd1));
        prog.push_back(enc_i(OP_ADDI, 3'd4, 3'd0, 6'd2));
        prog.push_back(enc_i(OP_BNE, 3'd2, 3'd1, 6'd8));
        prog.push_back(enc_i(OP_JMP, 3'd0, 3'd0, 6'd8));
        prog.push_back(enc_i(OP_ADDI, 3'd5, 3'd0, 6'd3));
        prog.push_back(enc_i(OP_ADDI, 3'd6, 3'd0, 6'd7));
        prog.push_back(enc_i(OP_BNE, 3'd6, 3'd1, 6'd11));
        prog.push_back(enc_i(OP_ADDI, 3'd7, 3'd0, 6'd9));
        prog.push_back(enc_i(OP_BEQ, 3'd6, 3'd1, 6'd13));
        prog.push_back(enc_r(OP_ADD, 3'd7, 3'd6, 3'd1));
        run_test("control_flow", prog);
    endtask

    // Opcode draws 5 to 7 become addi
    task automatic test_random_programs(input int count);
        word_t       prog[$];
        logic [31:0] sel, rs, rt, rd, imm;
        for (int p = 0; p < count; p++) begin
            prog.delete();
            for (int i = 0; i < 16; i++) begin
                take_bits(3, sel);
                take_bits(3, rs);
                take_bits(3, rt);
                take_bits(3, rd);
                take_bits(6, imm);
                if (sel < 5) begin
                    prog.push_back(enc_r(opcode_t'(sel[3:0]), rd[2:0], rs[2:0], rt[2:0]));
                end else begin
                    prog.push_back(enc_i(OP_ADDI, rt[2:0], rs[2:0], imm[5:0]));
                end
            end
            run_test($sformatf("random_%0d", p), prog);
        end
    endtask

    initial begin
        lfsr       = 32'hb159eb60;
        rst        = 1'b1;
        run        = 1'b0;
        load_req   = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        test_load_port();
        test_alu_forwarding();
        test_memory_and_load_use();
        test_control_flow();
        test_random_programs(4);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/memory_unit.sv
verilog/cpu.sv
tb/clock_gen.sv
tb/cpu_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f src.f --top-module cpu_tb -o cpu_sim

output=$(./obj_dir/cpu_sim || true)
echo "$output"

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
